// ==== src/rvfi_chk_pkg.sv ====
/*
 * Shared widths, cause and violation enums, and the packed trace records
 * used by the retirement trace monitor
 */

package rvfi_chk_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////////

  // Low bits of mcause that carry the exception code
  localparam int unsigned ExcCauseW  = 6;
  // Width of the dcsr.cause encoding
  localparam int unsigned DbgCauseW  = 3;
  // Width of the saturating violation counter
  localparam int unsigned ViolCountW = 8;
  // Number of checked rules, one flag each
  localparam int unsigned NumViol    = 7;

  //////////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////////

  // Debug entry causes as reported on the trace and in dcsr.cause
  typedef enum logic [DbgCauseW-1:0] {
    DBG_NONE    = 3'd0,
    DBG_EBREAK  = 3'd1,
    DBG_TRIGGER = 3'd2,
    DBG_HALTREQ = 3'd3,
    DBG_STEP    = 3'd4
  } dbg_cause_e;

  // Only the load and store exception codes matter to the atomic checks
  typedef enum logic [ExcCauseW-1:0] {
    EXC_LOAD_MISALIGNED  = 6'd4,
    EXC_LOAD_FAULT       = 6'd5,
    EXC_STORE_MISALIGNED = 6'd6,
    EXC_STORE_FAULT      = 6'd7
  } exc_cause_e;

  // Refinement of a memory fault, reported alongside the exception code
  typedef enum logic [1:0] {
    MEM_ERR_NONE,
    MEM_ERR_ATOMIC,
    MEM_ERR_IO_ALIGN
  } mem_err_e;

  // Kind of atomic instruction sitting in write-back
  typedef enum logic [1:0] {
    AT_NONE,
    AT_LR,
    AT_SC,
    AT_AMO
  } atomic_op_e;

  // One code per rule with V_NONE marking an empty first-violation record
  typedef enum logic [2:0] {
    V_TRAP_INTR,
    V_TRAP_MCAUSE,
    V_IRQ_ACK,
    V_DBG_NO_ACK,
    V_DBG_CAUSE,
    V_STEP_CAUSE,
    V_ATOMIC_CAUSE,
    V_NONE = 3'd7
  } viol_e;

  //////////////////////////////////////////////////////////////////////////
  // Records
  //////////////////////////////////////////////////////////////////////////

  // Trap information attached to a retired instruction
  typedef struct packed {
    logic       exception;
    logic       debug;
    exc_cause_e exception_cause;
    dbg_cause_e debug_cause;
    mem_err_e   cause_type;
  } trap_t;

  // One retirement as seen on the trace port
  typedef struct packed {
    logic                 valid;
    trap_t                trap;
    logic                 intr;
    dbg_cause_e           dbg;
    logic [ExcCauseW-1:0] mcause_low;
    logic                 dcsr_step;
    logic                 debug_mode;
  } retire_t;

  // Exception taken from write-back together with the LSU context
  typedef struct packed {
    logic       exc;
    logic       lsu_en;
    atomic_op_e atomic;
    logic       split;
  } wb_fault_t;

  // The field at bit i belongs to the viol_e code i
  typedef struct packed {
    logic atomic_cause;
    logic step_cause;
    logic dbg_cause;
    logic dbg_no_ack;
    logic irq_ack;
    logic trap_mcause;
    logic trap_intr;
  } viol_flags_t;

endpackage

// ==== src/trap_order_checker.sv ====
/*
 * Trap ordering checker for trap-to-handler sequencing on the trace
 * and for interrupt acknowledges reaching the next retirement
 */

`timescale 1ns/1ps

module trap_order_checker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  rvfi_chk_pkg::retire_t     retire_i,
  input  logic                      irq_ack_i,
  output rvfi_chk_pkg::viol_flags_t viol_o
);

  logic                     in_dbg;
  logic                     chk_en;
  logic                     trap_pend_q;
  logic                     trap_pend_d;
  rvfi_chk_pkg::exc_cause_e trap_cause_q;
  logic                     irq_pend_q;
  logic                     irq_pend_d;

  // Single stepping or debug mode suspends the trap rules since mcause
  // is not updated there
  assign in_dbg = retire_i.dcsr_step || retire_i.debug_mode;
  assign chk_en = retire_i.valid && !in_dbg;

  always_comb begin
    trap_pend_d = trap_pend_q;
    // Every retirement closes the window and a new trap reopens it
    if (retire_i.valid) begin
      trap_pend_d = chk_en && retire_i.trap.exception;
    end
  end

  always_comb begin
    irq_pend_d = irq_pend_q;
    if (retire_i.valid) begin
      irq_pend_d = 1'b0;
    end
    // An acknowledge is judged on a strictly later retirement
    if (irq_ack_i) begin
      irq_pend_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_pend_q <= 1'b0;
      irq_pend_q  <= 1'b0;
    end else begin
      trap_pend_q <= trap_pend_d;
      irq_pend_q  <= irq_pend_d;
    end
  end

  // Cause of the trap that armed the window
  always_ff @(posedge clk_i) begin
    if (chk_en && retire_i.trap.exception) begin
      trap_cause_q <= retire_i.trap.exception_cause;
    end
  end

  always_comb begin
    viol_o             = '0;
    // The first handler instruction must carry the interrupt marker
    viol_o.trap_intr   = trap_pend_q && chk_en && !retire_i.intr;
    viol_o.trap_mcause = trap_pend_q && chk_en && (retire_i.mcause_low != trap_cause_q);
    viol_o.irq_ack     = irq_pend_q && retire_i.valid && !retire_i.intr;
  end

endmodule

// ==== src/debug_entry_checker.sv ====
/*
 * Debug entry checker for acknowledge pairing, debug cause alignment
 * and the cause of an exception taken while single stepping
 */

`timescale 1ns/1ps

module debug_entry_checker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  rvfi_chk_pkg::retire_t     retire_i,
  input  logic                      dbg_ack_i,
  output rvfi_chk_pkg::viol_flags_t viol_o
);

  logic                     dbg_seen;
  logic [1:0]               ack_cnt_q;
  logic                     dbg_pend_q;
  rvfi_chk_pkg::dbg_cause_e dbg_cause_q;
  logic                     step_ok;

  // A debug entry shows up as a retirement with a nonzero debug cause
  assign dbg_seen = retire_i.valid && (retire_i.dbg != rvfi_chk_pkg::DBG_NONE);

  //////////////////////////////////////////////////////////////////////////
  // Outstanding acknowledges
  //////////////////////////////////////////////////////////////////////////

  // An acknowledge and an entry in the same cycle cancel each other
  // The counter holds at both ends so a bad trace cannot wrap it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_cnt_q <= 2'd0;
    end else begin
      if (dbg_ack_i && !dbg_seen && (ack_cnt_q != 2'd3)) begin
        ack_cnt_q <= ack_cnt_q + 2'd1;
      end else if (dbg_seen && !dbg_ack_i && (ack_cnt_q != 2'd0)) begin
        ack_cnt_q <= ack_cnt_q - 2'd1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Debug cause tracking
  //////////////////////////////////////////////////////////////////////////

  // A retirement flagged with trap.debug announces the entry that the
  // next retirement must report
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dbg_pend_q <= 1'b0;
    end else if (retire_i.valid) begin
      dbg_pend_q <= retire_i.trap.debug;
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire_i.valid && retire_i.trap.debug) begin
      dbg_cause_q <= retire_i.trap.debug_cause;
    end
  end

  // Exception plus debug only happens for a step or an exception trigger
  assign step_ok = (retire_i.trap.debug_cause == rvfi_chk_pkg::DBG_STEP) ||
                   (retire_i.trap.debug_cause == rvfi_chk_pkg::DBG_TRIGGER);

  always_comb begin
    viol_o            = '0;
    viol_o.dbg_no_ack = dbg_seen && (ack_cnt_q == 2'd0) && !dbg_ack_i;
    viol_o.dbg_cause  = dbg_pend_q && retire_i.valid && (retire_i.dbg != dbg_cause_q);
    viol_o.step_cause = retire_i.valid && retire_i.trap.exception &&
                        retire_i.trap.debug && !step_ok;
  end

endmodule

// ==== src/atomic_fault_checker.sv ====
/*
 * Atomic fault checker for the cause type and exception code reported
 * one cycle after an LR, SC or AMO faults in write-back
 */

`timescale 1ns/1ps

module atomic_fault_checker #(
  parameter bit amo_enable = 1'b1
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  rvfi_chk_pkg::wb_fault_t   fault_i,
  input  rvfi_chk_pkg::retire_t     retire_i,
  output rvfi_chk_pkg::viol_flags_t viol_o
);

  logic                     evt;
  logic                     evt_q;
  rvfi_chk_pkg::atomic_op_e op_q;
  logic                     split_q;
  rvfi_chk_pkg::exc_cause_e fault_code;
  rvfi_chk_pkg::exc_cause_e misal_code;
  logic                     atomic_fault;
  logic                     io_fault;
  logic                     io_misal;
  logic                     cause_ok;

  // Cores without AMO support never raise an AMO event here
  assign evt = fault_i.exc && fault_i.lsu_en && (fault_i.atomic != rvfi_chk_pkg::AT_NONE) &&
               (amo_enable || (fault_i.atomic != rvfi_chk_pkg::AT_AMO));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_q <= 1'b0;
    end else begin
      evt_q <= evt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (evt) begin
      op_q    <= fault_i.atomic;
      split_q <= fault_i.split;
    end
  end

  // LR reports load codes while SC and AMO report store codes
  assign fault_code = (op_q == rvfi_chk_pkg::AT_LR) ? rvfi_chk_pkg::EXC_LOAD_FAULT :
                                                      rvfi_chk_pkg::EXC_STORE_FAULT;
  assign misal_code = (op_q == rvfi_chk_pkg::AT_LR) ? rvfi_chk_pkg::EXC_LOAD_MISALIGNED :
                                                      rvfi_chk_pkg::EXC_STORE_MISALIGNED;

  assign atomic_fault = (retire_i.trap.cause_type == rvfi_chk_pkg::MEM_ERR_ATOMIC) &&
                        (retire_i.trap.exception_cause == fault_code);
  assign io_fault     = (retire_i.trap.cause_type == rvfi_chk_pkg::MEM_ERR_IO_ALIGN) &&
                        (retire_i.trap.exception_cause == fault_code);
  assign io_misal     = (retire_i.trap.cause_type == rvfi_chk_pkg::MEM_ERR_IO_ALIGN) &&
                        (retire_i.trap.exception_cause == misal_code);

  // A misaligned access may also be blocked by the PMA for either reason
  assign cause_ok = retire_i.valid && (split_q ? (atomic_fault || io_fault || io_misal) :
                                                 atomic_fault);

  always_comb begin
    viol_o              = '0;
    viol_o.atomic_cause = evt_q && !cause_ok;
  end

endmodule

// ==== src/violation_log.sv ====
/*
 * Violation log with sticky flags, a first-violation record and a
 * saturating count of all pulses
 */

`timescale 1ns/1ps

module violation_log (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  rvfi_chk_pkg::viol_flags_t           viol_i,
  output rvfi_chk_pkg::viol_flags_t           viol_flags_o,
  output rvfi_chk_pkg::viol_e                 first_viol_o,
  output logic [rvfi_chk_pkg::ViolCountW-1:0] viol_count_o
);

  logic [rvfi_chk_pkg::NumViol-1:0]    viol_vec;
  logic [rvfi_chk_pkg::ViolCountW-1:0] pulse_cnt;
  logic [rvfi_chk_pkg::ViolCountW:0]   count_sum;
  rvfi_chk_pkg::viol_e                 first_d;

  assign viol_vec = viol_i;

  // Scan from the top so that the lowest set code is the one kept
  always_comb begin
    pulse_cnt = '0;
    first_d   = rvfi_chk_pkg::V_NONE;
    for (int i = rvfi_chk_pkg::NumViol - 1; i >= 0; i--) begin
      if (viol_vec[i]) begin
        pulse_cnt = pulse_cnt + 1'b1;
        first_d   = rvfi_chk_pkg::viol_e'(i[2:0]);
      end
    end
  end

  // The extra top bit signals that the counter would overflow
  assign count_sum = {1'b0, viol_count_o} + {1'b0, pulse_cnt};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_flags_o <= '0;
      first_viol_o <= rvfi_chk_pkg::V_NONE;
      viol_count_o <= '0;
    end else begin
      viol_flags_o <= viol_flags_o | viol_i;
      viol_count_o <= count_sum[rvfi_chk_pkg::ViolCountW] ? '1 :
                      count_sum[rvfi_chk_pkg::ViolCountW-1:0];
      // Only the first cycle with any pulse is recorded
      if (first_viol_o == rvfi_chk_pkg::V_NONE) begin
        first_viol_o <= first_d;
      end
    end
  end

endmodule

// ==== src/rvfi_checker_top.sv ====
/*
 * Top level of the retirement trace monitor with the three rule
 * checkers feeding one violation log
 */

`timescale 1ns/1ps

module rvfi_checker_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  rvfi_chk_pkg::retire_t               retire_i,
  input  logic                                irq_ack_i,
  input  logic                                dbg_ack_i,
  input  rvfi_chk_pkg::wb_fault_t             fault_i,
  output rvfi_chk_pkg::viol_flags_t           viol_flags_o,
  output rvfi_chk_pkg::viol_e                 first_viol_o,
  output logic [rvfi_chk_pkg::ViolCountW-1:0] viol_count_o
);

  rvfi_chk_pkg::viol_flags_t viol_trap;
  rvfi_chk_pkg::viol_flags_t viol_dbg;
  rvfi_chk_pkg::viol_flags_t viol_atomic;
  rvfi_chk_pkg::viol_flags_t viol_all;

  trap_order_checker i_trap_order_checker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .retire_i  (retire_i),
    .irq_ack_i (irq_ack_i),
    .viol_o    (viol_trap)
  );

  debug_entry_checker i_debug_entry_checker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .retire_i  (retire_i),
    .dbg_ack_i (dbg_ack_i),
    .viol_o    (viol_dbg)
  );

  atomic_fault_checker #(
    .amo_enable (1'b1)
  ) i_atomic_fault_checker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .fault_i  (fault_i),
    .retire_i (retire_i),
    .viol_o   (viol_atomic)
  );

  // Each checker drives disjoint fields so the merge is a plain OR
  assign viol_all = viol_trap | viol_dbg | viol_atomic;

  violation_log i_violation_log (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .viol_i       (viol_all),
    .viol_flags_o (viol_flags_o),
    .first_viol_o (first_viol_o),
    .viol_count_o (viol_count_o)
  );

endmodule

// ==== test/tb_rvfi_checker.sv ====
/*
 * Testbench for the retirement trace monitor with directed and LFSR
 * stimulus, a reference model, per-cycle comparison and a watchdog
 */

`timescale 1ns/1ps

module tb_rvfi_checker;

  localparam int unsigned ClkPeriod      = 100;
  localparam int unsigned ResetCycles    = 10;
  localparam int unsigned NumAtomic      = 200;
  // The directed phases need about 40 cycles
  localparam int unsigned DirectedCycles = 80;
  localparam int unsigned TimeoutCycles  = ResetCycles + DirectedCycles + 2 * NumAtomic + 100;

  // State the reference model keeps between retirements
  typedef struct packed {
    logic                                  trap_pend;
    logic [rvfi_chk_pkg::ExcCauseW-1:0]    trap_cause;
    logic                                  irq_pend;
    logic [1:0]                            ack_cnt;
    logic                                  dbg_pend;
    rvfi_chk_pkg::dbg_cause_e              dbg_cause;
    logic                                  evt;
    rvfi_chk_pkg::atomic_op_e              op;
    logic                                  split;
    rvfi_chk_pkg::viol_flags_t             flags;
    rvfi_chk_pkg::viol_e                   first;
    logic [rvfi_chk_pkg::ViolCountW-1:0]   count;
  } model_t;

  logic                                clk_i;
  logic                                rst_ni;
  rvfi_chk_pkg::retire_t               retire_i;
  logic                                irq_ack_i;
  logic                                dbg_ack_i;
  rvfi_chk_pkg::wb_fault_t             fault_i;
  rvfi_chk_pkg::viol_flags_t           viol_flags_o;
  rvfi_chk_pkg::viol_e                 first_viol_o;
  logic [rvfi_chk_pkg::ViolCountW-1:0] viol_count_o;

  logic [31:0] lfsr_q = 32'he043_335d;
  model_t      model_q;
  int unsigned errors = 0;
  int unsigned checks = 0;

  rvfi_checker_top i_rvfi_checker_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .retire_i     (retire_i),
    .irq_ack_i    (irq_ack_i),
    .dbg_ack_i    (dbg_ack_i),
    .fault_i      (fault_i),
    .viol_flags_o (viol_flags_o),
    .first_viol_o (first_viol_o),
    .viol_count_o (viol_count_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random bits
  ////////////////////////////////////////////////////////////////////////////

  // Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Legal cause pairs after an atomic fault for each op and alignment
  function automatic logic atomic_legal(rvfi_chk_pkg::atomic_op_e op, logic split,
                                        rvfi_chk_pkg::retire_t r);
    logic atom;
    logic io;
    atom = (r.trap.cause_type == rvfi_chk_pkg::MEM_ERR_ATOMIC);
    io   = (r.trap.cause_type == rvfi_chk_pkg::MEM_ERR_IO_ALIGN);
    if (!r.valid) begin
      return 1'b0;
    end
    if (op == rvfi_chk_pkg::AT_LR) begin
      if (!split) begin
        return atom && (r.trap.exception_cause == rvfi_chk_pkg::EXC_LOAD_FAULT);
      end
      return (io && (r.trap.exception_cause == rvfi_chk_pkg::EXC_LOAD_MISALIGNED)) ||
             (atom && (r.trap.exception_cause == rvfi_chk_pkg::EXC_LOAD_FAULT)) ||
             (io && (r.trap.exception_cause == rvfi_chk_pkg::EXC_LOAD_FAULT));
    end
    if (!split) begin
      return atom && (r.trap.exception_cause == rvfi_chk_pkg::EXC_STORE_FAULT);
    end
    return (io && (r.trap.exception_cause == rvfi_chk_pkg::EXC_STORE_MISALIGNED)) ||
           (atom && (r.trap.exception_cause == rvfi_chk_pkg::EXC_STORE_FAULT)) ||
           (io && (r.trap.exception_cause == rvfi_chk_pkg::EXC_STORE_FAULT));
  endfunction

  function automatic model_t reset_model();
    model_t m;
    m       = '0;
    m.first = rvfi_chk_pkg::V_NONE;
    return m;
  endfunction

  // Expected state after one clock edge with the given inputs
  function automatic model_t next_model(model_t m, rvfi_chk_pkg::retire_t r, logic irq_ack,
                                        logic dbg_ack, rvfi_chk_pkg::wb_fault_t f);
    model_t                    n;
    rvfi_chk_pkg::viol_flags_t p;
    logic [6:0]                vec;
    logic                      chk;
    logic                      dbg_seen;
    int                        sum;
    int                        low;
    n        = m;
    p        = '0;
    chk      = r.valid && !r.dcsr_step && !r.debug_mode;
    dbg_seen = r.valid && (r.dbg != rvfi_chk_pkg::DBG_NONE);
    // Trap ordering and interrupt acknowledge
    p.trap_intr   = m.trap_pend && chk && !r.intr;
    p.trap_mcause = m.trap_pend && chk && (r.mcause_low != m.trap_cause);
    p.irq_ack     = m.irq_pend && r.valid && !r.intr;
    if (r.valid) begin
      n.trap_pend = chk && r.trap.exception;
      n.irq_pend  = 1'b0;
    end
    if (chk && r.trap.exception) begin
      n.trap_cause = r.trap.exception_cause;
    end
    if (irq_ack) begin
      n.irq_pend = 1'b1;
    end
    // The debug acknowledge count saturates at 0 and 3
    p.dbg_no_ack = dbg_seen && (m.ack_cnt == 2'd0) && !dbg_ack;
    p.dbg_cause  = m.dbg_pend && r.valid && (r.dbg != m.dbg_cause);
    p.step_cause = r.valid && r.trap.exception && r.trap.debug &&
                   (r.trap.debug_cause != rvfi_chk_pkg::DBG_STEP) &&
                   (r.trap.debug_cause != rvfi_chk_pkg::DBG_TRIGGER);
    if (dbg_ack && !dbg_seen && (m.ack_cnt != 2'd3)) begin
      n.ack_cnt = m.ack_cnt + 2'd1;
    end else if (dbg_seen && !dbg_ack && (m.ack_cnt != 2'd0)) begin
      n.ack_cnt = m.ack_cnt - 2'd1;
    end
    if (r.valid) begin
      n.dbg_pend = r.trap.debug;
      if (r.trap.debug) begin
        n.dbg_cause = r.trap.debug_cause;
      end
    end
    // Atomic fault judged on the retirement after the event
    p.atomic_cause = m.evt && !atomic_legal(m.op, m.split, r);
    n.evt = f.exc && f.lsu_en && (f.atomic != rvfi_chk_pkg::AT_NONE);
    if (n.evt) begin
      n.op    = f.atomic;
      n.split = f.split;
    end
    // Log update
    vec     = p;
    n.flags = m.flags | p;
    sum     = int'(m.count) + $countones(vec);
    if (sum >= (1 << rvfi_chk_pkg::ViolCountW)) begin
      n.count = '1;
    end else begin
      n.count = sum[rvfi_chk_pkg::ViolCountW-1:0];
    end
    low = 7;
    for (int i = 6; i >= 0; i--) begin
      if (vec[i]) begin
        low = i;
      end
    end
    if ((m.first == rvfi_chk_pkg::V_NONE) && (low != 7)) begin
      n.first = rvfi_chk_pkg::viol_e'(low[2:0]);
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic rvfi_chk_pkg::retire_t plain_retire();
    rvfi_chk_pkg::retire_t r;
    r       = '0;
    r.valid = 1'b1;
    return r;
  endfunction

  function automatic rvfi_chk_pkg::retire_t trap_retire(rvfi_chk_pkg::exc_cause_e c);
    rvfi_chk_pkg::retire_t r;
    r                      = plain_retire();
    r.trap.exception       = 1'b1;
    r.trap.exception_cause = c;
    return r;
  endfunction

  function automatic rvfi_chk_pkg::retire_t handler_retire(logic intr, logic [5:0] mcause);
    rvfi_chk_pkg::retire_t r;
    r            = plain_retire();
    r.intr       = intr;
    r.mcause_low = mcause;
    return r;
  endfunction

  task automatic drive(input rvfi_chk_pkg::retire_t r, input logic irq_ack,
                       input logic dbg_ack, input rvfi_chk_pkg::wb_fault_t f);
    @(posedge clk_i);
    retire_i  <= r;
    irq_ack_i <= irq_ack;
    dbg_ack_i <= dbg_ack;
    fault_i   <= f;
  endtask

  task automatic drive_idle(input int unsigned n);
    repeat (n) drive('0, 1'b0, 1'b0, '0);
  endtask

  // One idle edge lets the log register the last retirement
  task automatic expect_log(input logic [6:0] flags, input rvfi_chk_pkg::viol_e first,
                            input logic [7:0] count, input string what);
    drive_idle(1);
    @(negedge clk_i);
    checks = checks + 3;
    if (viol_flags_o != flags) begin
      errors++;
      $display("[ERROR] %0t: %s: flags %b, expected %b", $time, what, viol_flags_o, flags);
    end
    if (first_viol_o != first) begin
      errors++;
      $display("[ERROR] %0t: %s: first violation %s, expected %s", $time, what,
               first_viol_o.name(), first.name());
    end
    if (viol_count_o != count) begin
      errors++;
      $display("[ERROR] %0t: %s: count %0d, expected %0d", $time, what, viol_count_o, count);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Per-cycle comparison against the model
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    model_q = reset_model();
    forever begin
      @(negedge clk_i);
      checks = checks + 3;
      if (viol_flags_o !== model_q.flags) begin
        errors++;
        $display("[ERROR] %0t: viol_flags_o %b, expected %b", $time, viol_flags_o,
                 model_q.flags);
      end
      if (first_viol_o !== model_q.first) begin
        errors++;
        $display("[ERROR] %0t: first_viol_o %0d, expected %0d", $time, first_viol_o,
                 model_q.first);
      end
      if (viol_count_o !== model_q.count) begin
        errors++;
        $display("[ERROR] %0t: viol_count_o %0d, expected %0d", $time, viol_count_o,
                 model_q.count);
      end
      if (!rst_ni) begin
        model_q = reset_model();
      end else begin
        model_q = next_model(model_q, retire_i, irq_ack_i, dbg_ack_i, fault_i);
      end
    end
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Run timed out after %0d cycles without reaching the end", TimeoutCycles);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rvfi_chk_pkg::retire_t   r;
    rvfi_chk_pkg::wb_fault_t f;
    logic [31:0]             bits;
    rst_ni    = 1'b0;
    retire_i  = '0;
    irq_ack_i = 1'b0;
    dbg_ack_i = 1'b0;
    fault_i   = '0;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    expect_log(7'b0, rvfi_chk_pkg::V_NONE, 8'd0, "after reset");

    // Legal trace with a trap, an interrupt, a debug entry and an AMO fault
    drive(trap_retire(rvfi_chk_pkg::EXC_LOAD_FAULT), 1'b0, 1'b0, '0);
    drive(handler_retire(1'b1, 6'd5), 1'b0, 1'b0, '0);
    drive('0, 1'b1, 1'b0, '0);
    drive(handler_retire(1'b1, 6'd0), 1'b0, 1'b0, '0);
    drive('0, 1'b0, 1'b1, '0);
    r                  = plain_retire();
    r.trap.debug       = 1'b1;
    r.trap.debug_cause = rvfi_chk_pkg::DBG_EBREAK;
    drive(r, 1'b0, 1'b0, '0);
    r     = plain_retire();
    r.dbg = rvfi_chk_pkg::DBG_EBREAK;
    drive(r, 1'b0, 1'b0, '0);
    // A single step may enter debug together with an exception
    r                  = plain_retire();
    r.trap.exception   = 1'b1;
    r.trap.debug       = 1'b1;
    r.trap.debug_cause = rvfi_chk_pkg::DBG_STEP;
    r.dcsr_step        = 1'b1;
    drive(r, 1'b0, 1'b0, '0);
    drive('0, 1'b0, 1'b1, '0);
    r            = plain_retire();
    r.dbg        = rvfi_chk_pkg::DBG_STEP;
    r.debug_mode = 1'b1;
    drive(r, 1'b0, 1'b0, '0);
    f        = '0;
    f.exc    = 1'b1;
    f.lsu_en = 1'b1;
    f.atomic = rvfi_chk_pkg::AT_AMO;
    f.split  = 1'b1;
    drive('0, 1'b0, 1'b0, f);
    r                 = trap_retire(rvfi_chk_pkg::EXC_STORE_MISALIGNED);
    r.trap.cause_type = rvfi_chk_pkg::MEM_ERR_IO_ALIGN;
    drive(r, 1'b0, 1'b0, '0);
    drive(handler_retire(1'b1, 6'd6), 1'b0, 1'b0, '0);
    expect_log(7'b0, rvfi_chk_pkg::V_NONE, 8'd0, "legal trace");

    // Single stepping between trap and handler suspends the trap rules
    drive(trap_retire(rvfi_chk_pkg::EXC_LOAD_MISALIGNED), 1'b0, 1'b0, '0);
    r           = handler_retire(1'b0, 6'd0);
    r.dcsr_step = 1'b1;
    drive(r, 1'b0, 1'b0, '0);
    drive(handler_retire(1'b0, 6'd0), 1'b0, 1'b0, '0);
    expect_log(7'b0, rvfi_chk_pkg::V_NONE, 8'd0, "trap during step");

    // Missing marker and wrong mcause together count twice
    drive(trap_retire(rvfi_chk_pkg::EXC_LOAD_FAULT), 1'b0, 1'b0, '0);
    drive(handler_retire(1'b0, 6'd0), 1'b0, 1'b0, '0);
    expect_log(7'b0000011, rvfi_chk_pkg::V_TRAP_INTR, 8'd2, "trap without handler");
    drive(trap_retire(rvfi_chk_pkg::EXC_STORE_FAULT), 1'b0, 1'b0, '0);
    drive(handler_retire(1'b1, 6'd5), 1'b0, 1'b0, '0);
    expect_log(7'b0000011, rvfi_chk_pkg::V_TRAP_INTR, 8'd3, "wrong mcause");

    drive('0, 1'b1, 1'b0, '0);
    drive(handler_retire(1'b0, 6'd0), 1'b0, 1'b0, '0);
    expect_log(7'b0000111, rvfi_chk_pkg::V_TRAP_INTR, 8'd4, "lost interrupt");

    // Debug entry without acknowledge and then a cause mismatch
    r     = plain_retire();
    r.dbg = rvfi_chk_pkg::DBG_TRIGGER;
    drive(r, 1'b0, 1'b0, '0);
    drive('0, 1'b0, 1'b1, '0);
    r                  = plain_retire();
    r.trap.debug       = 1'b1;
    r.trap.debug_cause = rvfi_chk_pkg::DBG_HALTREQ;
    drive(r, 1'b0, 1'b0, '0);
    r     = plain_retire();
    r.dbg = rvfi_chk_pkg::DBG_EBREAK;
    drive(r, 1'b0, 1'b0, '0);
    // An exception entering debug by halt request is not a legal pair
    r                  = plain_retire();
    r.trap.exception   = 1'b1;
    r.trap.debug       = 1'b1;
    r.trap.debug_cause = rvfi_chk_pkg::DBG_HALTREQ;
    r.debug_mode       = 1'b1;
    drive(r, 1'b0, 1'b0, '0);
    drive('0, 1'b0, 1'b1, '0);
    r            = plain_retire();
    r.dbg        = rvfi_chk_pkg::DBG_HALTREQ;
    r.debug_mode = 1'b1;
    drive(r, 1'b0, 1'b0, '0);
    expect_log(7'b0111111, rvfi_chk_pkg::V_TRAP_INTR, 8'd7, "debug entry");

    // Four rules fire on one retirement
    drive(trap_retire(rvfi_chk_pkg::EXC_LOAD_FAULT), 1'b1, 1'b0, '0);
    r     = handler_retire(1'b0, 6'd0);
    r.dbg = rvfi_chk_pkg::DBG_STEP;
    drive(r, 1'b0, 1'b0, '0);
    expect_log(7'b0111111, rvfi_chk_pkg::V_TRAP_INTR, 8'd11, "four rules at once");

    // Random atomic faults each followed by a random cause pair
    for (int i = 0; i < NumAtomic; i++) begin
      f        = '0;
      f.exc    = 1'b1;
      bits     = rand_bits(3);
      f.lsu_en = |bits[2:0];
      bits     = rand_bits(2);
      f.atomic = rvfi_chk_pkg::atomic_op_e'(bits[1:0]);
      bits     = rand_bits(1);
      f.split  = bits[0];
      drive('0, 1'b0, 1'b0, f);
      r                      = plain_retire();
      bits                   = rand_bits(3);
      r.valid                = |bits[2:0];
      bits                   = rand_bits(2);
      r.trap.cause_type      = rvfi_chk_pkg::mem_err_e'(bits[1:0]);
      bits                   = rand_bits(2);
      r.trap.exception_cause = rvfi_chk_pkg::exc_cause_e'({4'd1, bits[1:0]});
      drive(r, 1'b0, 1'b0, '0);
    end

    drive_idle(3);
    @(negedge clk_i);
    @(posedge clk_i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
src/rvfi_chk_pkg.sv
src/trap_order_checker.sv
src/debug_entry_checker.sv
src/atomic_fault_checker.sv
src/violation_log.sv
src/rvfi_checker_top.sv
test/tb_rvfi_checker.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the retirement trace monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rvfi_checker \
  -f flist.f -Mdir obj_dir -o sim_tb_rvfi_checker
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_rvfi_checker)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
